// ==== source/mc_pkg.sv ====
package mc_pkg;

   // field widths shared by every block of the node
   localparam int mc_x_width    = 4;
   localparam int mc_y_width    = 4;
   localparam int mc_addr_width = 12;
   localparam int mc_data_width = 32;

   // request opcodes, stores only
   typedef enum logic [0:0] {
      mc_op_store_word = 1'b0,
      mc_op_store_byte = 1'b1
   } mc_op_e;

   // byte lane view of the payload word
   typedef struct packed {
      logic [21:0] unused;
      logic [1:0]  lane;
      logic [7:0]  value;
   } mc_byte_store_s;

   // payload is read either as a whole word or as a lane store
   typedef union packed {
      logic [mc_data_width-1:0] word;
      mc_byte_store_s           byte_view;
   } mc_payload_u;

   // credit packet, addressed back to the original sender
   typedef struct packed {
      logic [mc_x_width-1:0] x_cord;
      logic [mc_y_width-1:0] y_cord;
   } mc_return_pkt_s;

   // request packet on the forward net
   typedef struct packed {
      mc_op_e                   op;
      logic [mc_addr_width-1:0] addr;
      mc_payload_u              payload;
      mc_return_pkt_s           return_pkt;
   } mc_packet_s;

   // forward net half of a link
   // ready_and_rev answers the valid of the opposite direction
   typedef struct packed {
      logic       v;
      mc_packet_s data;
      logic       ready_and_rev;
   } mc_fwd_link_s;

   // reverse net half, carries credits
   typedef struct packed {
      logic           v;
      mc_return_pkt_s data;
      logic           ready_and_rev;
   } mc_rev_link_s;

   // one direction of a full link
   typedef struct packed {
      mc_fwd_link_s fwd;
      mc_rev_link_s rev;
   } mc_link_sif_s;

endpackage

// ==== source/mc_fifo_small.sv ====
`timescale 1ns/100ps

module mc_fifo_small #(
   parameter int width_p = 8,
   parameter int els_p   = 4
) (
   input  logic               clk_i,
   input  logic               reset_i,

   input  logic               v_i,
   input  logic [width_p-1:0] data_i,
   output logic               ready_o,

   output logic               v_o,
   output logic [width_p-1:0] data_o,
   input  logic               yumi_i
);

   localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

   logic [width_p-1:0]      mem_r [els_p];
   logic [ptr_width_lp-1:0] wptr_r;
   logic [ptr_width_lp-1:0] rptr_r;
   // equal pointers mean full if the last change was a write
   logic                    last_write_r;
   logic                    full;
   logic                    empty;
   logic                    enq;
   logic                    deq;

   assign full  = (wptr_r == rptr_r) & last_write_r;
   assign empty = (wptr_r == rptr_r) & ~last_write_r;

   assign ready_o = ~full;
   assign v_o     = ~empty;
   assign data_o  = mem_r[rptr_r];

   assign enq = v_i & ready_o;
   assign deq = yumi_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wptr_r       <= '0;
         rptr_r       <= '0;
         last_write_r <= 1'b0;
      end else begin
         if (enq) begin
            wptr_r <= (wptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
         end
         if (deq) begin
            rptr_r <= (rptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
         end
         if (enq & ~deq) begin
            last_write_r <= 1'b1;
         end else if (deq & ~enq) begin
            last_write_r <= 1'b0;
         end
      end
   end

   // entry storage written at the write pointer
   always_ff @(posedge clk_i) begin
      if (enq) begin
         mem_r[wptr_r] <= data_i;
      end
   end

   a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      yumi_i |-> v_o);

   // a full buffer without a pop must not move its write pointer
   a_no_write_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
      (full && !yumi_i) |=> ($stable(wptr_r) && full));

endmodule

// ==== source/mc_endpoint.sv ====
`timescale 1ns/100ps

module mc_endpoint #(
   parameter int fifo_els_p = 4
) (
   input  logic                 clk_i,
   input  logic                 reset_i,

   // link to the mesh
   input  mc_pkg::mc_link_sif_s link_sif_i,
   output mc_pkg::mc_link_sif_s link_sif_o,

   // incoming requests for the local side
   output mc_pkg::mc_packet_s   fifo_data_o,
   output logic                 fifo_v_o,
   input  logic                 fifo_yumi_i,

   // outgoing requests from the local side
   input  mc_pkg::mc_packet_s   out_data_i,
   input  logic                 out_v_i,
   output logic                 out_ready_o,

   // one cycle pulse per arriving credit
   output logic                 credit_v_r_o
);

   import mc_pkg::*;

   logic fifo_v;
   logic credit_v_r;

   mc_fifo_small #(
      .width_p ($bits(mc_packet_s)),
      .els_p   (fifo_els_p)
   ) u_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .v_i     (link_sif_i.fwd.v),
      .data_i  (link_sif_i.fwd.data),
      .ready_o (link_sif_o.fwd.ready_and_rev),
      .v_o     (fifo_v),
      .data_o  (fifo_data_o),
      .yumi_i  (fifo_yumi_i)
   );

   // only offer the head when its credit can go out
   assign fifo_v_o = fifo_v & link_sif_i.rev.ready_and_rev;

   // credit leaves in the same cycle the head is consumed
   assign link_sif_o.rev.v    = fifo_yumi_i;
   assign link_sif_o.rev.data = fifo_data_o.return_pkt;

   // outgoing requests go straight onto the forward net
   assign link_sif_o.fwd.v    = out_v_i;
   assign link_sif_o.fwd.data = out_data_i;
   assign out_ready_o         = link_sif_i.fwd.ready_and_rev;

   // credits are never back-pressured
   assign link_sif_o.rev.ready_and_rev = 1'b1;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         credit_v_r <= 1'b0;
      end else begin
         credit_v_r <= link_sif_i.rev.v;
      end
   end

   assign credit_v_r_o = credit_v_r;

   // the responder must not consume a head that is hidden
   a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      fifo_yumi_i |-> fifo_v_o);

endmodule

// ==== source/mc_credit_counter.sv ====
`timescale 1ns/100ps

module mc_credit_counter #(
   parameter int max_credits_p = 4
) (
   input  logic clk_i,
   input  logic reset_i,

   // local request valid in, gated valid out to the endpoint
   input  logic req_v_i,
   output logic req_v_o,

   // forward net ready from the endpoint, ready back to the local side
   input  logic link_ready_i,
   output logic req_ready_o,

   // registered credit pulse
   input  logic credit_v_i
);

   localparam int cnt_width_lp = $clog2(max_credits_p + 1);

   logic [cnt_width_lp-1:0] count_r;
   logic                    have_credit;
   logic                    send;

   assign have_credit = (count_r < cnt_width_lp'(max_credits_p));

   // valid is gated by credits only, not by the link ready
   assign req_v_o     = req_v_i & have_credit;
   assign req_ready_o = have_credit & link_ready_i;

   assign send = req_v_o & link_ready_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count_r <= '0;
      end else begin
         // send and credit in one cycle cancel out
         case ({send, credit_v_i})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

   a_count_limit: assert property (@(posedge clk_i) disable iff (reset_i)
      count_r <= cnt_width_lp'(max_credits_p));

   // a credit only comes back for a request sent at least two cycles earlier
   a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
      credit_v_i |-> (count_r != '0));

endmodule

// ==== source/mc_store_responder.sv ====
`timescale 1ns/100ps

module mc_store_responder #(
   parameter int mem_words_p = 64
) (
   input  logic                             clk_i,
   input  logic                             reset_i,

   // incoming requests from the endpoint
   input  mc_pkg::mc_packet_s               pkt_i,
   input  logic                             pkt_v_i,
   output logic                             yumi_o,

   // read port for inspection
   input  logic [mc_pkg::mc_addr_width-1:0] rd_addr_i,
   output logic [mc_pkg::mc_data_width-1:0] rd_data_o
);

   import mc_pkg::*;

   localparam int idx_width_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

   logic [mc_data_width-1:0] mem_r [mem_words_p];
   logic [idx_width_lp-1:0]  wr_idx;
   logic [idx_width_lp-1:0]  rd_idx;
   mc_payload_u              payload;
   logic [mc_data_width-1:0] old_word;
   logic [mc_data_width-1:0] new_word;

   // every valid packet is a store, so take it at once
   assign yumi_o = pkt_v_i;

   // only the low address bits select a word
   assign wr_idx = idx_width_lp'(pkt_i.addr % mem_words_p);
   assign rd_idx = idx_width_lp'(rd_addr_i % mem_words_p);

   assign payload  = pkt_i.payload;
   assign old_word = mem_r[wr_idx];

   // merge the store into the current word
   always_comb begin
      new_word = old_word;
      case (pkt_i.op)
         mc_op_store_word: begin
            new_word = payload.word;
         end
         mc_op_store_byte: begin
            new_word[payload.byte_view.lane*8 +: 8] = payload.byte_view.value;
         end
         default: begin
            new_word = old_word;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < mem_words_p; i++) begin
            mem_r[i] <= '0;
         end
      end else if (yumi_o) begin
         mem_r[wr_idx] <= new_word;
      end
   end

   assign rd_data_o = mem_r[rd_idx];

endmodule

// ==== source/mc_node_top.sv ====
`timescale 1ns/100ps

module mc_node_top #(
   parameter int fifo_els_p    = 4,
   parameter int mem_words_p   = 64,
   parameter int max_credits_p = 4
) (
   input  logic                             clk_i,
   input  logic                             reset_i,

   // mesh link
   input  mc_pkg::mc_link_sif_s             link_sif_i,
   output mc_pkg::mc_link_sif_s             link_sif_o,

   // local outgoing requests
   input  mc_pkg::mc_packet_s               out_pkt_i,
   input  logic                             out_v_i,
   output logic                             out_ready_o,

   // memory read port
   input  logic [mc_pkg::mc_addr_width-1:0] rd_addr_i,
   output logic [mc_pkg::mc_data_width-1:0] rd_data_o
);

   import mc_pkg::*;

   mc_packet_s fifo_data;
   logic       fifo_v;
   logic       fifo_yumi;
   logic       out_v_gated;
   logic       link_fwd_ready;
   logic       credit_v;

   mc_endpoint #(
      .fifo_els_p (fifo_els_p)
   ) u_endpoint (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .link_sif_i   (link_sif_i),
      .link_sif_o   (link_sif_o),
      .fifo_data_o  (fifo_data),
      .fifo_v_o     (fifo_v),
      .fifo_yumi_i  (fifo_yumi),
      .out_data_i   (out_pkt_i),
      .out_v_i      (out_v_gated),
      .out_ready_o  (link_fwd_ready),
      .credit_v_r_o (credit_v)
   );

   mc_credit_counter #(
      .max_credits_p (max_credits_p)
   ) u_credit_counter (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_v_i      (out_v_i),
      .req_v_o      (out_v_gated),
      .link_ready_i (link_fwd_ready),
      .req_ready_o  (out_ready_o),
      .credit_v_i   (credit_v)
   );

   mc_store_responder #(
      .mem_words_p (mem_words_p)
   ) u_store_responder (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .pkt_i     (fifo_data),
      .pkt_v_i   (fifo_v),
      .yumi_o    (fifo_yumi),
      .rd_addr_i (rd_addr_i),
      .rd_data_o (rd_data_o)
   );

endmodule

// ==== tb/mc_node_tb.sv ====
`timescale 1ns/100ps

module mc_node_tb;

   import mc_pkg::*;

   localparam int fifo_els_lp       = 4;
   localparam int mem_words_lp      = 64;
   localparam int max_credits_lp    = 4;
   localparam int num_tests_lp      = 5;
   localparam int txn_per_test_lp   = 300;
   localparam int timeout_cycles_lp = num_tests_lp * txn_per_test_lp * 20;

   logic                     clk_i = 1'b0;
   logic                     reset_i;
   mc_link_sif_s             link_in;
   mc_link_sif_s             link_out;
   mc_packet_s               out_pkt_i;
   logic                     out_v_i;
   logic                     out_ready_o;
   logic [mc_addr_width-1:0] rd_addr_i;
   logic [mc_data_width-1:0] rd_data_o;

   // remote neighbour and local sender
   mc_packet_s               in_pkt;
   bit                       in_pend;
   mc_packet_s               out_pkt;
   bit                       out_pend;

   // traffic knobs in percent per cycle
   int                       offer_pct;
   int                       out_pct;
   int                       byte_pct;
   int                       fwd_rdy_pct;
   int                       rev_rdy_pct;
   int                       credit_delay;
   logic [mc_addr_width-1:0] addr_mask;
   bit                       offer_en;
   bit                       out_en;
   bit                       rev_hold_low;

   // reference models
   logic [mc_data_width-1:0] mem_model [mem_words_lp];
   mc_return_pkt_s           exp_credit_q [$];
   mc_packet_s               store_q [$];
   mc_packet_s               exp_out_q [$];
   int                       cred_due_q [$];
   int                       outstanding;
   bit                       credit_d;
   int                       fifo_cnt;
   int                       in_count;
   int                       out_count;
   int                       limit_hits;

   string                    cur_test;
   int                       checks;
   int                       errors;
   int                       test_errors;
   int                       cycle_count = 0;

   mc_node_top u_dut (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .link_sif_i  (link_in),
      .link_sif_o  (link_out),
      .out_pkt_i   (out_pkt_i),
      .out_v_i     (out_v_i),
      .out_ready_o (out_ready_o),
      .rd_addr_i   (rd_addr_i),
      .rd_data_o   (rd_data_o)
   );

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles_lp) begin
         $display("timeout: run stopped after %0d cycles in %s", cycle_count, cur_test);
         $display(">>> FAIL");
         $finish;
      end
   end

   function automatic bit chance(int pct);
      return int'($urandom % 100) < pct;
   endfunction

   function automatic mc_packet_s random_packet();
      mc_packet_s pkt;
      pkt.op                = chance(byte_pct) ? mc_op_store_byte : mc_op_store_word;
      pkt.addr              = mc_addr_width'($urandom) & addr_mask;
      pkt.payload.word      = $urandom;
      pkt.return_pkt.x_cord = mc_x_width'($urandom);
      pkt.return_pkt.y_cord = mc_y_width'($urandom);
      return pkt;
   endfunction

   // a word store replaces all lanes and a byte store only its own lane
   function automatic void apply_store(mc_packet_s pkt);
      int idx;
      int lane_lo;
      idx     = int'(pkt.addr) % mem_words_lp;
      lane_lo = 8 * int'(pkt.payload.byte_view.lane);
      if (pkt.op == mc_op_store_word) begin
         mem_model[idx] = pkt.payload.word;
      end else begin
         mem_model[idx][lane_lo +: 8] = pkt.payload.byte_view.value;
      end
   endfunction

   task automatic check_value(string what, logic [63:0] exp_v, logic [63:0] act_v);
      checks++;
      assert (exp_v === act_v) else begin
         $display("Mismatch %s %s: expected %0h, actual %0h", cur_test, what, exp_v, act_v);
         errors++;
         test_errors++;
      end
   endtask

   task automatic check_true(bit cond, string msg);
      checks++;
      assert (cond) else begin
         $display("Error in %s: %s", cur_test, msg);
         errors++;
         test_errors++;
      end
   endtask

   task automatic drive_inputs();
      if (!in_pend && offer_en && chance(offer_pct)) begin
         in_pkt  = random_packet();
         in_pend = 1'b1;
      end
      if (!out_pend && out_en && chance(out_pct)) begin
         out_pkt  = random_packet();
         out_pend = 1'b1;
      end
      link_in.fwd.v             = in_pend;
      link_in.fwd.data          = in_pkt;
      link_in.fwd.ready_and_rev = chance(fwd_rdy_pct);
      link_in.rev.ready_and_rev = rev_hold_low ? 1'b0 : chance(rev_rdy_pct);
      link_in.rev.data          = mc_return_pkt_s'(8'($urandom));
      // return at most one credit per cycle
      link_in.rev.v             = 1'b0;
      if (cred_due_q.size() > 0 && cred_due_q[0] <= cycle_count) begin
         link_in.rev.v = 1'b1;
         void'(cred_due_q.pop_front());
      end
      out_v_i   = out_pend;
      out_pkt_i = out_pkt;
      rd_addr_i = mc_addr_width'($urandom);
   endtask

   // sampled at the rising edge before the registers update
   task automatic observe_outputs();
      bit             in_acc;
      bit             rev_beat;
      bit             loc_send;
      bit             link_send;
      bit             have_credit;
      mc_return_pkt_s ret;
      mc_packet_s     pkt;
      in_acc      = link_in.fwd.v && link_out.fwd.ready_and_rev;
      rev_beat    = link_out.rev.v;
      loc_send    = out_v_i && out_ready_o;
      link_send   = link_out.fwd.v && link_in.fwd.ready_and_rev;
      have_credit = outstanding < max_credits_lp;
      if (!have_credit) begin
         limit_hits++;
      end
      check_value("read port", 64'(mem_model[int'(rd_addr_i) % mem_words_lp]), 64'(rd_data_o));
      check_value("forward ready", 64'(fifo_cnt < fifo_els_lp), 64'(link_out.fwd.ready_and_rev));
      check_value("credit valid", 64'(fifo_cnt > 0 && link_in.rev.ready_and_rev), 64'(rev_beat));
      check_value("out ready", 64'(have_credit && link_in.fwd.ready_and_rev), 64'(out_ready_o));
      check_value("forward valid", 64'(out_v_i && have_credit), 64'(link_out.fwd.v));
      check_true(link_send == loc_send, "forward transfer does not match the local handshake");
      check_true(link_out.rev.ready_and_rev, "node refuses incoming credits");
      if (rev_beat) begin
         check_true(link_in.rev.ready_and_rev, "credit sent while reverse ready is low");
         if (exp_credit_q.size() == 0) begin
            check_true(1'b0, "credit sent with no packet accepted");
         end else begin
            ret = exp_credit_q.pop_front();
            check_value("credit data", 64'(ret), 64'(link_out.rev.data));
            apply_store(store_q.pop_front());
            fifo_cnt--;
         end
      end
      if (loc_send) begin
         exp_out_q.push_back(out_pkt);
         out_pend = 1'b0;
         out_count++;
      end
      if (link_send) begin
         if (exp_out_q.size() == 0) begin
            check_true(1'b0, "forward packet sent with nothing offered");
         end else begin
            pkt = exp_out_q.pop_front();
            check_value("forward packet", 64'(pkt), 64'(link_out.fwd.data));
         end
         cred_due_q.push_back(cycle_count + 1 + int'($urandom % credit_delay));
         outstanding++;
      end
      // credit pulse is registered once inside the node
      if (credit_d) begin
         outstanding--;
      end
      credit_d = link_in.rev.v;
      check_true(outstanding <= max_credits_lp, "outstanding count above the credit limit");
      if (in_acc) begin
         exp_credit_q.push_back(in_pkt.return_pkt);
         store_q.push_back(in_pkt);
         fifo_cnt++;
         in_pend = 1'b0;
         in_count++;
      end
   endtask

   task automatic run_cycle();
      @(posedge clk_i);
      observe_outputs();
      @(negedge clk_i);
      drive_inputs();
   endtask

   function automatic bit all_idle();
      return !in_pend && !out_pend && exp_credit_q.size() == 0 && store_q.size() == 0
         && exp_out_q.size() == 0 && cred_due_q.size() == 0 && outstanding == 0
         && !credit_d && fifo_cnt == 0;
   endfunction

   task automatic drain();
      offer_en     = 1'b0;
      out_en       = 1'b0;
      rev_hold_low = 1'b0;
      fwd_rdy_pct  = 100;
      rev_rdy_pct  = 100;
      run_cycle();
      while (!all_idle()) begin
         run_cycle();
      end
   endtask

   // the random high address bits must not change the selected word
   task automatic sweep_memory();
      logic [mc_addr_width-1:0] addr;
      for (int a = 0; a < mem_words_lp; a++) begin
         addr = mc_addr_width'(a + mem_words_lp * int'($urandom % 8));
         @(negedge clk_i);
         rd_addr_i = addr;
         @(posedge clk_i);
         check_value("memory word", 64'(mem_model[a]), 64'(rd_data_o));
      end
   endtask

   task automatic set_knobs(int offer, int outp, int bytes, int fwd, int rev, int delay,
                            logic [mc_addr_width-1:0] mask);
      offer_pct    = offer;
      out_pct      = outp;
      byte_pct     = bytes;
      fwd_rdy_pct  = fwd;
      rev_rdy_pct  = rev;
      credit_delay = delay;
      addr_mask    = mask;
      offer_en     = 1'b1;
      out_en       = 1'b1;
      rev_hold_low = 1'b0;
   endtask

   task automatic start_test(string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic finish_test(int txns);
      $display("test %s done: %0d transactions, %0d errors", cur_test, txns, test_errors);
   endtask

   // counts incoming accepts or local sends when count_out is set
   task automatic traffic_test(bit count_out);
      int base;
      int done;
      base = count_out ? out_count : in_count;
      done = 0;
      while (done < txn_per_test_lp) begin
         run_cycle();
         done = (count_out ? out_count : in_count) - base;
      end
      drain();
      sweep_memory();
   endtask

   task automatic back_pressure_test();
      int base;
      int held;
      int txns;
      start_test("back_pressure");
      txns = 0;
      while (txns < txn_per_test_lp) begin
         set_knobs(100, 0, 50, 100, 0, 4, 12'h03f);
         rev_hold_low = 1'b1;
         base = in_count;
         repeat (fifo_els_lp + 6) run_cycle();
         held = in_count - base;
         check_value("accepted while held", 64'(fifo_els_lp), 64'(held));
         check_true(!link_out.fwd.ready_and_rev, "forward ready still high with a full FIFO");
         drain();
         txns += held;
      end
      sweep_memory();
      finish_test(txns);
   endtask

   initial begin
      void'($urandom(32'h4021f355));
      reset_i     = 1'b1;
      link_in     = '0;
      out_pkt_i   = '0;
      out_v_i     = 1'b0;
      rd_addr_i   = '0;
      in_pkt      = '0;
      out_pkt     = '0;
      in_pend     = 1'b0;
      out_pend    = 1'b0;
      credit_d    = 1'b0;
      outstanding = 0;
      fifo_cnt    = 0;
      in_count    = 0;
      out_count   = 0;
      limit_hits  = 0;
      checks      = 0;
      errors      = 0;
      test_errors = 0;
      cur_test    = "reset";
      set_knobs(0, 0, 0, 100, 100, 1, '0);
      for (int i = 0; i < mem_words_lp; i++) begin
         mem_model[i] = '0;
      end
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      start_test("word_store");
      set_knobs(70, 30, 0, 70, 60, 8, 12'hfff);
      traffic_test(1'b0);
      finish_test(txn_per_test_lp);

      // narrow address range so lanes of one word are hit many times
      start_test("byte_store");
      set_knobs(70, 20, 80, 80, 70, 8, 12'h00f);
      traffic_test(1'b0);
      finish_test(txn_per_test_lp);

      start_test("outgoing");
      set_knobs(30, 80, 50, 50, 80, 4, 12'hfff);
      traffic_test(1'b1);
      finish_test(txn_per_test_lp);

      // slow credit return keeps the counter at its limit
      start_test("credit_limit");
      set_knobs(20, 100, 50, 90, 80, 30, 12'h03f);
      limit_hits = 0;
      traffic_test(1'b1);
      check_true(limit_hits > 0, "credit limit was never reached");
      finish_test(txn_per_test_lp);

      back_pressure_test();

      $display("summary: %0d tests, %0d checks, %0d errors", num_tests_lp, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
source/mc_pkg.sv
source/mc_fifo_small.sv
source/mc_endpoint.sv
source/mc_credit_counter.sv
source/mc_store_responder.sv
source/mc_node_top.sv
tb/mc_node_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the node testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 \
   --top-module mc_node_tb -f flist.f -o mc_node_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/mc_node_sim > sim.log 2>&1
cat sim.log

grep -qx ">>> PASS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
